// ==== flist.f ====
+incdir+source
source/video_pkg.sv
source/video_frame_source.sv
source/component_gain.sv
source/stream_join.sv
source/video_gain_top.sv
test/tb_clock_gen.sv
test/tb_video_gain.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the video gain testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_video_gain \
    -f flist.f

sim_out=$(./obj_dir/Vtb_video_gain)
echo "$sim_out"

# pass only when the testbench printed its pass line
if grep -qx "ALL CHECKS PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== source/component_gain.sv ====
// ***************************************************************************
// one gain lane, a single register stage holding one component
// result is (comp * gain) >> VID_GAIN_SHIFT, clipped to the component range
// the gain is taken at the cycle the beat is loaded
// ***************************************************************************
`include "video_cfg.svh"

module component_gain (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  video_pkg::gain_t      gain,
    input  video_pkg::lane_beat_t in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,
    output video_pkg::lane_beat_t out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    localparam int PROD_WIDTH = `VID_DATA_WIDTH + `VID_GAIN_WIDTH;

    logic [PROD_WIDTH-1:0] product;
    logic [PROD_WIDTH-1:0] scaled;
    logic                  overflow;
    video_pkg::comp_t      sat_comp;
    logic                  load;

    assign product  = PROD_WIDTH'(in_beat.comp) * PROD_WIDTH'(gain);
    assign scaled   = product >> `VID_GAIN_SHIFT;    // drop the fraction bits
    assign overflow = |scaled[PROD_WIDTH-1:`VID_DATA_WIDTH];
    assign sat_comp = overflow ? '1 : scaled[`VID_DATA_WIDTH-1:0];

    // the stage frees itself when its content leaves in the same cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            out_beat.side <= in_beat.side;  // tags pass unchanged
            out_beat.comp <= sat_comp;
        end
    end

    // a stalled beat keeps both its valid and its content
    a_out_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

// ==== source/stream_join.sv ====
// ***************************************************************************
// merges the gain lanes back into one output register stage
// lanes are loaded together, so their valids and tags must always agree
// sideband of the output beat is taken from lane 0
// ***************************************************************************
`include "video_cfg.svh"

module stream_join (
    input  logic                                        aclk,
    input  logic                                        aresetn,
    input  video_pkg::lane_beat_t [`VID_COMPONENTS-1:0] lane_out,
    input  logic [`VID_COMPONENTS-1:0]                  lane_out_valid,
    output logic                                        join_ready,
    output video_pkg::video_beat_t                      m_beat,
    output logic                                        m_valid,
    input  logic                                        m_ready
);

    logic              all_valid;
    logic              can_take;     // output register empty or draining now
    logic              side_match;
    video_pkg::pixel_t pixel;

    assign all_valid  = &lane_out_valid;
    assign can_take   = !m_valid || m_ready;
    assign join_ready = all_valid && can_take;

    always_comb begin
        pixel = '0;
        for (int k = 0; k < `VID_COMPONENTS; k++) begin
            pixel[k*`VID_DATA_WIDTH +: `VID_DATA_WIDTH] = lane_out[k].comp;
        end
    end

    // every lane has to carry the tags of lane 0
    always_comb begin
        side_match = 1'b1;
        for (int k = 1; k < `VID_COMPONENTS; k++) begin
            if (lane_out[k].side != lane_out[0].side) begin
                side_match = 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_valid <= 1'b0;
        end else if (can_take) begin
            m_valid <= all_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (join_ready) begin
            m_beat.side <= lane_out[0].side;
            m_beat.data <= pixel;
        end
    end

    // lanes fill and drain in lock step
    a_lanes_aligned: assert property (@(posedge aclk) disable iff (!aresetn)
        (lane_out_valid == '0) || all_valid);

    a_sides_equal: assert property (@(posedge aclk) disable iff (!aresetn)
        all_valid |-> side_match);

endmodule

// ==== source/video_cfg.svh ====
// ***************************************************************************
// dimensions of the raster video pipeline, shared by RTL and testbench
// X_NUM+X_BLANK and Y_NUM+Y_BLANK must fit in VID_COORD_WIDTH bits
// gains are unsigned fixed point with VID_GAIN_SHIFT fraction bits
// ***************************************************************************
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// pixel format
`define VID_COMPONENTS      3       // components per pixel
`define VID_DATA_WIDTH      8       // bits per component

// raster, active area and blanking
`define VID_X_NUM           8
`define VID_Y_NUM           4
`define VID_X_BLANK         2       // idle columns at the end of each line
`define VID_Y_BLANK         1       // idle rows at the end of each frame
`define VID_COORD_WIDTH     16
`define VID_FRAME_WIDTH     16

// gain format, a gain of 1 << VID_GAIN_SHIFT is unity
`define VID_GAIN_WIDTH      8
`define VID_GAIN_SHIFT      4

`endif

// ==== source/video_frame_source.sv ====
// ***************************************************************************
// raster frame source with built-in x / y / frame number pattern
// one frame is produced per enable sampled while idle, busy covers it
// blank positions cost one idle cycle each, active ones wait for all lanes
// ***************************************************************************
`include "video_cfg.svh"

module video_frame_source (
    input  logic                                        aclk,
    input  logic                                        aresetn,
    input  logic                                        enable,
    input  logic [`VID_COMPONENTS-1:0]                  lane_ready,
    output logic                                        busy,
    output video_pkg::frame_t                           frame_num,
    output video_pkg::lane_beat_t [`VID_COMPONENTS-1:0] fork_beat,
    output logic                                        fork_valid
);

    localparam video_pkg::coord_t X_ACTIVE = video_pkg::coord_t'(`VID_X_NUM);
    localparam video_pkg::coord_t Y_ACTIVE = video_pkg::coord_t'(`VID_Y_NUM);
    localparam video_pkg::coord_t X_EOL    = video_pkg::coord_t'(`VID_X_NUM - 1);
    localparam video_pkg::coord_t X_LAST   = video_pkg::coord_t'(`VID_X_NUM + `VID_X_BLANK - 1);
    localparam video_pkg::coord_t Y_LAST   = video_pkg::coord_t'(`VID_Y_NUM + `VID_Y_BLANK - 1);

    video_pkg::source_state_t state;
    video_pkg::coord_t        x;
    video_pkg::coord_t        y;
    video_pkg::sideband_t     side;
    logic                     active;     // raster position inside the visible area
    logic                     step;       // leave the current raster position

    assign active     = (x < X_ACTIVE) && (y < Y_ACTIVE);
    assign busy       = (state == video_pkg::RUN);
    assign fork_valid = busy && active;
    // blank positions pass by themselves, active ones need every lane ready
    assign step       = busy && (!active || (&lane_ready));

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state     <= video_pkg::IDLE;
            x         <= '0;
            y         <= '0;
            frame_num <= '0;
        end else begin
            case (state)
                video_pkg::IDLE: begin
                    if (enable) begin
                        state <= video_pkg::RUN;    // x and y are already at the origin
                    end
                end
                video_pkg::RUN: begin
                    if (step) begin
                        if (x == X_LAST) begin
                            x <= '0;
                            if (y == Y_LAST) begin
                                y         <= '0;
                                state     <= video_pkg::IDLE;
                                frame_num <= frame_num + 1'b1;
                            end else begin
                                y <= y + 1'b1;
                            end
                        end else begin
                            x <= x + 1'b1;
                        end
                    end
                end
                default: state <= video_pkg::IDLE;
            endcase
        end
    end

    always_comb begin
        side.user = (x == '0) && (y == '0);
        side.last = (x == X_EOL);
        side.x    = x;
        side.y    = y;
        side.f    = frame_num;
    end

    // test pattern, every lane gets the same tags and its own component
    always_comb begin
        for (int k = 0; k < `VID_COMPONENTS; k++) begin
            fork_beat[k].side = side;
            case (k)
                0:       fork_beat[k].comp = video_pkg::comp_t'(x);
                1:       fork_beat[k].comp = video_pkg::comp_t'(y);
                2:       fork_beat[k].comp = video_pkg::comp_t'(frame_num);
                default: fork_beat[k].comp = '0;
            endcase
        end
    end

    // an offered beat stays put until every lane has taken it
    a_fork_held: assert property (@(posedge aclk) disable iff (!aresetn)
        fork_valid && !(&lane_ready) |=> fork_valid && $stable(fork_beat));

endmodule

// ==== source/video_gain_top.sv ====
// ***************************************************************************
// video gain pipeline, frame source forked to one gain lane per component
// and joined into a single valid/ready output stream
// source acceptance to m_valid takes two cycles
// ***************************************************************************
`include "video_cfg.svh"

module video_gain_top (
    input  logic                                   aclk,
    input  logic                                   aresetn,
    input  logic                                   enable,
    input  video_pkg::gain_t [`VID_COMPONENTS-1:0] gains,
    output logic                                   busy,
    output video_pkg::frame_t                      frame_num,
    output video_pkg::video_beat_t                 m_beat,
    output logic                                   m_valid,
    input  logic                                   m_ready
);

    video_pkg::lane_beat_t [`VID_COMPONENTS-1:0] fork_beat;
    logic                                        fork_valid;
    logic [`VID_COMPONENTS-1:0]                  lane_ready;
    video_pkg::lane_beat_t [`VID_COMPONENTS-1:0] lane_out;
    logic [`VID_COMPONENTS-1:0]                  lane_out_valid;
    logic                                        join_ready;    // shared by all lanes

    video_frame_source u_source (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .enable     (enable),
        .lane_ready (lane_ready),
        .busy       (busy),
        .frame_num  (frame_num),
        .fork_beat  (fork_beat),
        .fork_valid (fork_valid)
    );

    generate
        for (genvar k = 0; k < `VID_COMPONENTS; k++) begin : g_lane
            component_gain u_gain (
                .aclk      (aclk),
                .aresetn   (aresetn),
                .gain      (gains[k]),
                .in_beat   (fork_beat[k]),
                .in_valid  (fork_valid),
                .in_ready  (lane_ready[k]),
                .out_beat  (lane_out[k]),
                .out_valid (lane_out_valid[k]),
                .out_ready (join_ready)
            );
        end
    endgenerate

    stream_join u_join (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .lane_out       (lane_out),
        .lane_out_valid (lane_out_valid),
        .join_ready     (join_ready),
        .m_beat         (m_beat),
        .m_valid        (m_valid),
        .m_ready        (m_ready)
    );

endmodule

// ==== source/video_pkg.sv ====
// ***************************************************************************
// types shared by the video gain pipeline
// widths come from video_cfg.svh, pixel_t holds component k in slice k
// ***************************************************************************
`include "video_cfg.svh"

package video_pkg;

    typedef logic [`VID_DATA_WIDTH-1:0]                 comp_t;
    typedef logic [`VID_COMPONENTS*`VID_DATA_WIDTH-1:0] pixel_t;
    typedef logic [`VID_COORD_WIDTH-1:0]                coord_t;
    typedef logic [`VID_FRAME_WIDTH-1:0]                frame_t;
    typedef logic [`VID_GAIN_WIDTH-1:0]                 gain_t;    // unsigned fixed point

    // tags that travel with every beat
    typedef struct packed {
        logic   user;       // start of frame
        logic   last;       // end of line
        coord_t x;
        coord_t y;
        frame_t f;
    } sideband_t;

    // what a single gain lane holds
    typedef struct packed {
        sideband_t side;
        comp_t     comp;
    } lane_beat_t;

    // the merged beat at the output port
    typedef struct packed {
        sideband_t side;
        pixel_t    data;
    } video_beat_t;

    typedef enum logic {
        IDLE,
        RUN
    } source_state_t;

endpackage

// ==== test/tb_clock_gen.sv ====
// ***************************************************************************
// clock and reset for the video gain testbench
// reset is held low for RESET_CYCLES rising edges, released 1 unit after one
// ***************************************************************************

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever begin
            #(PERIOD / 2);
            aclk = ~aclk;
        end
    end

    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        aresetn = 1'b1;    // released off the edge like every other input
    end

endmodule

// ==== test/tb_video_gain.sv ====
// ***************************************************************************
// table-driven testbench for the video gain pipeline
// each table row sets three gains, a stall rate on m_ready and a frame count
// expected beats come from a raster walk and the gain rule
// the model covers exactly three components
// ***************************************************************************
`include "video_cfg.svh"

module tb_video_gain;

    localparam int NUM_ROWS        = 5;
    localparam int RASTER_CYCLES   = (`VID_X_NUM + `VID_X_BLANK) * (`VID_Y_NUM + `VID_Y_BLANK);
    localparam int BEATS_PER_FRAME = `VID_X_NUM * `VID_Y_NUM;
    localparam int COMP_MAX        = (1 << `VID_DATA_WIDTH) - 1;
    localparam int START_LATENCY   = 3;    // one cycle to go busy, then two register stages

    typedef struct {
        int gain0;
        int gain1;
        int gain2;
        int stall_pct;
        int frames;
    } row_t;

    logic                                   aclk;
    logic                                   aresetn;
    logic                                   enable;
    video_pkg::gain_t [`VID_COMPONENTS-1:0] gains;
    logic                                   m_ready;
    logic                                   busy;
    video_pkg::frame_t                      frame_num;
    video_pkg::video_beat_t                 m_beat;
    logic                                   m_valid;

    row_t                   rows [NUM_ROWS];
    video_pkg::video_beat_t exp_q [$];       // beats still due at the output
    logic [31:0]            lfsr_state;
    int                     stall_pct;
    int                     frame_beats;
    int                     check_count;
    int                     error_count;
    int                     cycle_count = 0;
    int                     cycle_limit = 0;

    tb_clock_gen #(
        .PERIOD       (8),
        .RESET_CYCLES (3)
    ) u_clock (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    video_gain_top dut (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .enable    (enable),
        .gains     (gains),
        .busy      (busy),
        .frame_num (frame_num),
        .m_beat    (m_beat),
        .m_valid   (m_valid),
        .m_ready   (m_ready)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int draw_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);   // newest bit lands in the lsb
        end
        return value;
    endfunction

    function automatic video_pkg::comp_t apply_gain(input int value, input int gain);
        int scaled;
        scaled = (value * gain) >> `VID_GAIN_SHIFT;
        if (scaled > COMP_MAX) begin
            scaled = COMP_MAX;
        end
        return video_pkg::comp_t'(scaled);
    endfunction

    function automatic string describe_beat(input video_pkg::video_beat_t beat);
        return $sformatf("x %0d y %0d f %0d user %b last %b data %h", beat.side.x,
                         beat.side.y, beat.side.f, beat.side.user, beat.side.last, beat.data);
    endfunction

    // expected beats of one frame in raster order, blank positions give none
    task automatic queue_frame(input int f, input row_t row);
        video_pkg::video_beat_t beat;
        for (int y = 0; y < `VID_Y_NUM; y++) begin
            for (int x = 0; x < `VID_X_NUM; x++) begin
                beat.side.user = (x == 0) && (y == 0);
                beat.side.last = (x == `VID_X_NUM - 1);
                beat.side.x    = video_pkg::coord_t'(x);
                beat.side.y    = video_pkg::coord_t'(y);
                beat.side.f    = video_pkg::frame_t'(f);
                beat.data      = {apply_gain(f & COMP_MAX, row.gain2),
                                  apply_gain(y & COMP_MAX, row.gain1),
                                  apply_gain(x & COMP_MAX, row.gain0)};
                exp_q.push_back(beat);
            end
        end
    endtask

    task automatic compare_beat(input video_pkg::video_beat_t got,
                                input video_pkg::video_beat_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t: %s got %s, expected %s", $time, what, describe_beat(got),
                     describe_beat(exp));
        end
    endtask

    task automatic compare_frame(input video_pkg::frame_t got, input video_pkg::frame_t exp,
                                 input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        check_count++;
        if (got != exp) begin
            error_count++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    // entered and left 1 unit after a rising edge with the pipeline empty
    task automatic run_frame(input row_t row, input int f);
        int cycles;
        frame_beats = 0;
        queue_frame(f, row);
        compare_flag(busy, 1'b0, "busy before enable");
        compare_frame(frame_num, video_pkg::frame_t'(f), "frame_num before enable");
        enable = 1'b1;
        next_cycle();
        enable = 1'b0;
        compare_flag(busy, 1'b1, "busy after enable");
        if (row.stall_pct == 0) begin
            cycles = 1;
            while (!m_valid) begin
                next_cycle();
                cycles++;
            end
            compare_count(cycles, START_LATENCY, "cycles from enable to first m_valid");
        end
        while (busy) begin
            next_cycle();
        end
        compare_frame(frame_num, video_pkg::frame_t'(f + 1), "frame_num after frame");
        while (m_valid) begin
            next_cycle();       // tail of the frame still draining
        end
        compare_count(frame_beats, BEATS_PER_FRAME, "beats in frame");
        exp_q.delete();
        repeat (3) begin
            next_cycle();
            compare_flag(m_valid, 1'b0, "m_valid between frames");
            compare_flag(busy, 1'b0, "busy between frames");
        end
    endtask

    // m_ready follows the stall rate read at the edge, 7 LFSR bits per cycle
    initial begin
        int pct;
        forever begin
            @(posedge aclk);
            pct = stall_pct;
            #1;
            if (pct > 0) begin
                m_ready = ((draw_bits(7) * 100) >> 7) >= pct;
            end else begin
                m_ready = 1'b1;
            end
        end
    end

    // every accepted beat must be the next one due
    always @(negedge aclk) begin
        if (aresetn && m_valid && m_ready) begin
            frame_beats++;
            if (exp_q.size() == 0) begin
                error_count++;
                $display("unexpected beat at time %0t (x %0d y %0d f %0d) while no frame was due",
                         $time, m_beat.side.x, m_beat.side.y, m_beat.side.f);
            end else begin
                compare_beat(m_beat, exp_q.pop_front(), "output beat");
            end
        end
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int frame;
        int errors_before;
        enable      = 1'b0;
        gains       = '0;
        m_ready     = 1'b0;
        stall_pct   = 0;
        lfsr_state  = 32'hcc6f1e47;
        frame_beats = 0;
        check_count = 0;
        error_count = 0;

        rows[0] = '{16, 16, 16, 0, 2};      // unity gain, start latency
        rows[1] = '{16, 40, 255, 0, 3};
        rows[2] = '{255, 255, 255, 50, 4};  // heavy back-pressure
        rows[3] = '{40, 255, 16, 25, 6};
        rows[4] = '{16, 40, 255, 0, 8};     // component 2 clips from frame 17 on

        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += 4 * rows[r].frames * (RASTER_CYCLES + 4);
        end

        @(posedge aresetn);
        next_cycle();
        compare_flag(busy, 1'b0, "busy after reset");
        compare_flag(m_valid, 1'b0, "m_valid after reset");
        compare_frame(frame_num, '0, "frame_num after reset");

        frame = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            errors_before = error_count;
            gains[0]  = video_pkg::gain_t'(rows[r].gain0);
            gains[1]  = video_pkg::gain_t'(rows[r].gain1);
            gains[2]  = video_pkg::gain_t'(rows[r].gain2);
            stall_pct = rows[r].stall_pct;
            for (int n = 0; n < rows[r].frames; n++) begin
                run_frame(rows[r], frame);
                frame++;
            end
            $display("row %0d: gains %0d %0d %0d, stall %0d%%, %0d frames, %0d errors",
                     r, rows[r].gain0, rows[r].gain1, rows[r].gain2, rows[r].stall_pct,
                     rows[r].frames, error_count - errors_before);
        end

        $display("%0d checks done, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
